/* Bender.yml */
package:
  name: serial_read_engine

sources:
  # Design sources in compile order
  - files:
      - logic/mem_req_pkg.sv
      - logic/read_engine_pkg.sv
      - logic/addr_step_if.sv
      - logic/read_sequencer.sv
      - logic/stride_walker.sv
      - logic/request_queue.sv
      - logic/serial_read_engine.sv

  # Testbench, checker and clock
  - target: test
    files:
      - tests/tb_clock_gen.sv
      - tests/serial_read_engine_chk.sv
      - tests/serial_read_engine_tb.sv

/* logic/addr_step_if.sv */
interface addr_step_if
    import mem_req_pkg::*;
();

    // Offset walker controls
    logic                  load;
    logic [ADDR_WIDTH-1:0] load_value;
    logic [ADDR_WIDTH-1:0] stride;
    logic                  step;

    // Current offset, read by sequencer and queue
    logic [ADDR_WIDTH-1:0] count;

    modport sequencer (
        output load, load_value, stride, step,
        input  count
    );

    modport walker (
        input  load, load_value, stride, step,
        output count
    );

    modport queue (input count);

endinterface : addr_step_if

/* logic/mem_req_pkg.sv */
package mem_req_pkg;

    // ------------------------------
    // Request packet field widths
    // ------------------------------

    // Base address and offset share one width
    localparam int ADDR_WIDTH = 32;

    // Command field of a packet
    localparam int CMD_WIDTH = 2;

    // Engine identifier carried back with each response
    localparam int ID_WIDTH = 8;

    // ------------------------------
    // Command codes
    // ------------------------------

    localparam logic [CMD_WIDTH-1:0] CMD_READ = 2'b01;

endpackage : mem_req_pkg

/* logic/read_engine_pkg.sv */
package read_engine_pkg;

    // ------------------------------
    // Request queue sizing
    // ------------------------------

    localparam int QUEUE_DEPTH = 16;
    localparam int QUEUE_PTR_WIDTH = $clog2(QUEUE_DEPTH);

    // Level needs one more bit to hold a full queue
    localparam int QUEUE_LEVEL_WIDTH = QUEUE_PTR_WIDTH + 1;

    // Generation stops here, margin for requests in flight
    localparam int PAUSE_LEVEL = 12;

    // ------------------------------
    // Sequencer states
    // ------------------------------

    typedef enum logic [2:0] {
        RESET, IDLE, SETUP, BUSY, PAUSE, DONE
    } seq_state_t;

endpackage : read_engine_pkg

/* logic/read_sequencer.sv */
module read_sequencer
    import mem_req_pkg::*;
    import read_engine_pkg::*;
(
    input  logic                  ap_clk,
    input  logic                  engine_areset,
    input  logic                  cfg_valid,
    input  logic                  start,
    input  logic [ADDR_WIDTH-1:0] cfg_array_pointer,
    input  logic [ADDR_WIDTH-1:0] cfg_start_read,
    input  logic [ADDR_WIDTH-1:0] cfg_end_read,
    input  logic [ADDR_WIDTH-1:0] cfg_stride,
    input  logic                  nearly_full,
    addr_step_if.sequencer        step_bus,
    output logic                  issue,
    output logic [ADDR_WIDTH-1:0] base_address,
    output logic                  engine_ready,
    output logic                  engine_done
);

    seq_state_t state;
    seq_state_t next_state;

    logic accept;
    logic end_reached;

    // Captured configuration
    logic [ADDR_WIDTH-1:0] array_pointer_reg;
    logic [ADDR_WIDTH-1:0] start_read_reg;
    logic [ADDR_WIDTH-1:0] end_read_reg;
    logic [ADDR_WIDTH-1:0] stride_reg;

    assign accept      = (state == IDLE) && cfg_valid && start;
    assign end_reached = (step_bus.count >= end_read_reg);

    always_ff @(posedge ap_clk) begin
        if (accept) begin
            array_pointer_reg <= cfg_array_pointer;
            start_read_reg    <= cfg_start_read;
            end_read_reg      <= cfg_end_read;
            stride_reg        <= cfg_stride;
        end
    end

    // ------------------------------
    // State machine
    // ------------------------------

    always_ff @(posedge ap_clk) begin
        if (engine_areset) begin
            state <= RESET;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            RESET: begin
                next_state = IDLE;
            end
            IDLE: begin
                if (accept) begin
                    next_state = SETUP;
                end
            end
            // Walker loads here, count is valid in BUSY
            SETUP: begin
                next_state = BUSY;
            end
            BUSY: begin
                if (end_reached) begin
                    next_state = DONE;
                end else if (nearly_full) begin
                    next_state = PAUSE;
                end
            end
            PAUSE: begin
                if (!nearly_full) begin
                    next_state = BUSY;
                end
            end
            DONE: begin
                next_state = IDLE;
            end
            default: begin
                next_state = RESET;
            end
        endcase
    end

    // ------------------------------
    // Outputs
    // ------------------------------

    // One request per cycle while below end and queue has room
    assign issue = (state == BUSY) && !end_reached && !nearly_full;

    assign step_bus.load       = (state == SETUP);
    assign step_bus.load_value = start_read_reg;
    assign step_bus.stride     = stride_reg;
    assign step_bus.step       = issue;

    assign base_address = array_pointer_reg;
    assign engine_ready = (state == IDLE);
    assign engine_done  = (state == DONE);

endmodule : read_sequencer

/* logic/request_queue.sv */
module request_queue
    import mem_req_pkg::*;
    import read_engine_pkg::*;
#(
    parameter logic [ID_WIDTH-1:0] ENGINE_ID = '0
) (
    input  logic                  ap_clk,
    input  logic                  engine_areset,
    input  logic                  issue,
    input  logic [ADDR_WIDTH-1:0] base_address,
    addr_step_if.queue            step_bus,
    output logic                  nearly_full,
    output logic                  req_valid,
    input  logic                  req_ready,
    output logic [ADDR_WIDTH-1:0] req_base_address,
    output logic [ADDR_WIDTH-1:0] req_address_offset,
    output logic [CMD_WIDTH-1:0]  req_cmd_type,
    output logic [ID_WIDTH-1:0]   req_engine_id
);

    // Entry storage, base and offset kept side by side
    logic [ADDR_WIDTH-1:0] base_mem   [QUEUE_DEPTH];
    logic [ADDR_WIDTH-1:0] offset_mem [QUEUE_DEPTH];

    logic [QUEUE_PTR_WIDTH-1:0]   wr_ptr;
    logic [QUEUE_PTR_WIDTH-1:0]   rd_ptr;
    logic [QUEUE_LEVEL_WIDTH-1:0] level;

    logic push;
    logic pop;

    assign push = issue;
    assign pop  = req_valid && req_ready;

    // ------------------------------
    // Storage write
    // ------------------------------

    always_ff @(posedge ap_clk) begin
        if (push) begin
            base_mem[wr_ptr]   <= base_address;
            offset_mem[wr_ptr] <= step_bus.count;
        end
    end

    // ------------------------------
    // Pointers and fill level
    // ------------------------------

    always_ff @(posedge ap_clk) begin
        if (engine_areset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leaves the level alone
            if (push && !pop) begin
                level <= level + 1'b1;
            end else if (pop && !push) begin
                level <= level - 1'b1;
            end
        end
    end

    assign nearly_full = (level >= QUEUE_LEVEL_WIDTH'(PAUSE_LEVEL));

    // ------------------------------
    // Head of queue
    // ------------------------------

    assign req_valid          = (level != '0);
    assign req_base_address   = base_mem[rd_ptr];
    assign req_address_offset = offset_mem[rd_ptr];
    assign req_cmd_type       = CMD_READ;
    assign req_engine_id      = ENGINE_ID;

endmodule : request_queue

/* logic/serial_read_engine.sv */
module serial_read_engine
    import mem_req_pkg::*;
#(
    parameter logic [ID_WIDTH-1:0] ENGINE_ID = '0
) (
    input  logic                  ap_clk,
    input  logic                  engine_areset,

    // Configuration and start
    input  logic                  cfg_valid,
    input  logic [ADDR_WIDTH-1:0] cfg_array_pointer,
    input  logic [ADDR_WIDTH-1:0] cfg_start_read,
    input  logic [ADDR_WIDTH-1:0] cfg_end_read,
    input  logic [ADDR_WIDTH-1:0] cfg_stride,
    input  logic                  start,

    // Engine status
    output logic                  engine_ready,
    output logic                  engine_done,

    // Memory request port
    output logic                  req_valid,
    input  logic                  req_ready,
    output logic [ADDR_WIDTH-1:0] req_base_address,
    output logic [ADDR_WIDTH-1:0] req_address_offset,
    output logic [CMD_WIDTH-1:0]  req_cmd_type,
    output logic [ID_WIDTH-1:0]   req_engine_id
);

    logic                  issue;
    logic [ADDR_WIDTH-1:0] base_address;
    logic                  nearly_full;

    addr_step_if step_bus ();

    // ------------------------------
    // Control and offset arithmetic
    // ------------------------------

    read_sequencer read_sequencer_inst (
        .ap_clk            (ap_clk),
        .engine_areset     (engine_areset),
        .cfg_valid         (cfg_valid),
        .start             (start),
        .cfg_array_pointer (cfg_array_pointer),
        .cfg_start_read    (cfg_start_read),
        .cfg_end_read      (cfg_end_read),
        .cfg_stride        (cfg_stride),
        .nearly_full       (nearly_full),
        .step_bus          (step_bus.sequencer),
        .issue             (issue),
        .base_address      (base_address),
        .engine_ready      (engine_ready),
        .engine_done       (engine_done)
    );

    stride_walker stride_walker_inst (
        .ap_clk        (ap_clk),
        .engine_areset (engine_areset),
        .step_bus      (step_bus.walker)
    );

    // ------------------------------
    // Packet build and buffering
    // ------------------------------

    request_queue #(
        .ENGINE_ID (ENGINE_ID)
    ) request_queue_inst (
        .ap_clk             (ap_clk),
        .engine_areset      (engine_areset),
        .issue              (issue),
        .base_address       (base_address),
        .step_bus           (step_bus.queue),
        .nearly_full        (nearly_full),
        .req_valid          (req_valid),
        .req_ready          (req_ready),
        .req_base_address   (req_base_address),
        .req_address_offset (req_address_offset),
        .req_cmd_type       (req_cmd_type),
        .req_engine_id      (req_engine_id)
    );

endmodule : serial_read_engine

/* logic/stride_walker.sv */
module stride_walker (
    input  logic       ap_clk,
    input  logic       engine_areset,
    addr_step_if.walker step_bus
);

    // ------------------------------
    // Offset register
    // ------------------------------

    // Load wins over step, the sequencer never raises both
    always_ff @(posedge ap_clk) begin
        if (engine_areset) begin
            step_bus.count <= '0;
        end else if (step_bus.load) begin
            step_bus.count <= step_bus.load_value;
        end else if (step_bus.step) begin
            step_bus.count <= step_bus.count + step_bus.stride;
        end
    end

endmodule : stride_walker

/* serial_read_engine.f */
logic/mem_req_pkg.sv
logic/read_engine_pkg.sv
logic/addr_step_if.sv
logic/read_sequencer.sv
logic/stride_walker.sv
logic/request_queue.sv
logic/serial_read_engine.sv
tests/tb_clock_gen.sv
tests/serial_read_engine_chk.sv
tests/serial_read_engine_tb.sv

/* tests/serial_read_engine_chk.sv */
module serial_read_engine_chk
    import mem_req_pkg::*;
(
    input logic                  ap_clk,
    input logic                  engine_areset,
    input logic                  engine_ready,
    input logic                  engine_done,
    input logic                  req_valid,
    input logic                  req_ready,
    input logic [ADDR_WIDTH-1:0] req_base_address,
    input logic [ADDR_WIDTH-1:0] req_address_offset,
    input logic [CMD_WIDTH-1:0]  req_cmd_type,
    input logic [ID_WIDTH-1:0]   req_engine_id
);

    timeunit 1ns;
    timeprecision 1ps;

    // Number of failed assertions
    int unsigned assert_failures = 0;

    // ------------------------------
    // Request port
    // ------------------------------

    // Stalled packet must hold until it transfers
    stall_hold : assert property (
        @(posedge ap_clk) disable iff (engine_areset)
        (req_valid && !req_ready) |=> (req_valid
            && $stable(req_base_address) && $stable(req_address_offset)
            && $stable(req_cmd_type) && $stable(req_engine_id))
    ) else begin
        $error("request fields changed while the port was stalled");
        assert_failures++;
    end

    reset_clears_outputs : assert property (
        @(posedge ap_clk) engine_areset |=> (!req_valid && !engine_done)
    ) else begin
        $error("req_valid or engine_done high right after reset");
        assert_failures++;
    end

    // ------------------------------
    // Control outputs
    // ------------------------------

    done_single_cycle : assert property (
        @(posedge ap_clk) disable iff (engine_areset)
        engine_done |=> !engine_done
    ) else begin
        $error("engine_done stayed high for more than one cycle");
        assert_failures++;
    end

    ready_done_exclusive : assert property (
        @(posedge ap_clk) disable iff (engine_areset)
        !(engine_ready && engine_done)
    ) else begin
        $error("engine_ready and engine_done high in the same cycle");
        assert_failures++;
    end

endmodule : serial_read_engine_chk

bind serial_read_engine serial_read_engine_chk serial_read_engine_chk_inst (.*);

/* tests/serial_read_engine_tb.sv */
module serial_read_engine_tb
    import mem_req_pkg::*;
    import read_engine_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT_CYCLES = 2000;
    localparam logic [ID_WIDTH-1:0] TB_ENGINE_ID = 8'h5A;

    // req_ready drive modes
    localparam int READY_HIGH   = 0;
    localparam int READY_LOW    = 1;
    localparam int READY_TOGGLE = 2;
    localparam int READY_RANDOM = 3;

    logic                  ap_clk;
    logic                  engine_areset;
    logic                  cfg_valid;
    logic [ADDR_WIDTH-1:0] cfg_array_pointer;
    logic [ADDR_WIDTH-1:0] cfg_start_read;
    logic [ADDR_WIDTH-1:0] cfg_end_read;
    logic [ADDR_WIDTH-1:0] cfg_stride;
    logic                  start;
    logic                  engine_ready;
    logic                  engine_done;
    logic                  req_valid;
    logic                  req_ready;
    logic [ADDR_WIDTH-1:0] req_base_address;
    logic [ADDR_WIDTH-1:0] req_address_offset;
    logic [CMD_WIDTH-1:0]  req_cmd_type;
    logic [ID_WIDTH-1:0]   req_engine_id;

    int     ready_mode;
    integer seed;
    int     error_count;
    int     tests_run;
    int     tests_failed;
    int     done_count;

    // Expected and received request lists
    logic [ADDR_WIDTH-1:0] exp_offset [$];
    logic [ADDR_WIDTH-1:0] exp_base [$];
    logic [ADDR_WIDTH-1:0] got_offset [$];
    logic [ADDR_WIDTH-1:0] got_base [$];
    logic [CMD_WIDTH-1:0]  got_cmd [$];
    logic [ID_WIDTH-1:0]   got_id [$];

    tb_clock_gen clock_gen_inst (
        .ap_clk (ap_clk)
    );

    serial_read_engine #(
        .ENGINE_ID (TB_ENGINE_ID)
    ) serial_read_engine_inst (
        .ap_clk             (ap_clk),
        .engine_areset      (engine_areset),
        .cfg_valid          (cfg_valid),
        .cfg_array_pointer  (cfg_array_pointer),
        .cfg_start_read     (cfg_start_read),
        .cfg_end_read       (cfg_end_read),
        .cfg_stride         (cfg_stride),
        .start              (start),
        .engine_ready       (engine_ready),
        .engine_done        (engine_done),
        .req_valid          (req_valid),
        .req_ready          (req_ready),
        .req_base_address   (req_base_address),
        .req_address_offset (req_address_offset),
        .req_cmd_type       (req_cmd_type),
        .req_engine_id      (req_engine_id)
    );

    // ------------------------------
    // Monitor and req_ready driver
    // ------------------------------

    // Mid-cycle sample, the transfer itself happens on the next rising edge
    always @(negedge ap_clk) begin
        if (req_valid && req_ready) begin
            got_offset.push_back(req_address_offset);
            got_base.push_back(req_base_address);
            got_cmd.push_back(req_cmd_type);
            got_id.push_back(req_engine_id);
        end
        if (engine_done) begin
            done_count++;
        end
    end

    always @(posedge ap_clk) begin : ready_drive
        logic next_ready;
        case (ready_mode)
            READY_LOW:    next_ready = 1'b0;
            READY_TOGGLE: next_ready = !req_ready;
            READY_RANDOM: next_ready = $random(seed) & 1;
            default:      next_ready = 1'b1;
        endcase
        #1;
        req_ready = next_ready;
    end

    // ------------------------------
    // Helpers
    // ------------------------------

    task automatic next_cycle();
        @(posedge ap_clk);
        #1;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic clear_records();
        exp_offset.delete();
        exp_base.delete();
        got_offset.delete();
        got_base.delete();
        got_cmd.delete();
        got_id.delete();
        done_count = 0;
    endtask

    // Offsets from start upward by stride, all strictly below end
    task automatic build_expected(input logic [31:0] pointer, input logic [31:0] start_off,
                                  input logic [31:0] end_off, input logic [31:0] stride);
        logic [31:0] off;
        off = start_off;
        while (off < end_off) begin
            exp_offset.push_back(off);
            exp_base.push_back(pointer);
            off = off + stride;
        end
    endtask

    task automatic wait_for_ready();
        int cycles;
        cycles = 0;
        while (!engine_ready && cycles < TIMEOUT_CYCLES) begin
            next_cycle();
            cycles++;
        end
        if (!engine_ready) begin
            $display("Timeout: engine_ready stayed low for %0d cycles", TIMEOUT_CYCLES);
            error_count++;
        end
    endtask

    task automatic launch(input logic [31:0] pointer, input logic [31:0] start_off,
                          input logic [31:0] end_off, input logic [31:0] stride);
        wait_for_ready();
        cfg_array_pointer = pointer;
        cfg_start_read    = start_off;
        cfg_end_read      = end_off;
        cfg_stride        = stride;
        cfg_valid         = 1'b1;
        start             = 1'b1;
        next_cycle();
        cfg_valid = 1'b0;
        start     = 1'b0;
    endtask

    task automatic wait_for_done(input int target);
        int cycles;
        cycles = 0;
        while (done_count < target && cycles < TIMEOUT_CYCLES) begin
            next_cycle();
            cycles++;
        end
        if (done_count < target) begin
            $display("Timeout: engine_done did not pulse within %0d cycles", TIMEOUT_CYCLES);
            error_count++;
        end
    endtask

    task automatic wait_for_drain();
        int cycles;
        cycles = 0;
        while ((got_offset.size() < exp_offset.size() || req_valid)
               && cycles < TIMEOUT_CYCLES) begin
            next_cycle();
            cycles++;
        end
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: request queue did not drain within %0d cycles",
                     TIMEOUT_CYCLES);
            error_count++;
        end
    endtask

    task automatic compare_requests();
        int n;
        check_value("request count", got_offset.size(), exp_offset.size());
        n = (got_offset.size() < exp_offset.size()) ? got_offset.size() : exp_offset.size();
        for (int i = 0; i < n; i++) begin
            check_value($sformatf("req_address_offset[%0d]", i), got_offset[i], exp_offset[i]);
            check_value($sformatf("req_base_address[%0d]", i), got_base[i], exp_base[i]);
            check_value($sformatf("req_cmd_type[%0d]", i), got_cmd[i], CMD_READ);
            check_value($sformatf("req_engine_id[%0d]", i), got_id[i], TB_ENGINE_ID);
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (error_count == errors_before) begin
            $display("%-22s ok", name);
        end else begin
            tests_failed++;
            $display("%-22s failed with %0d errors", name, error_count - errors_before);
        end
    endtask

    // ------------------------------
    // Directed tests
    // ------------------------------

    task automatic test_reset_values();
        int errors_before;
        errors_before = error_count;
        engine_areset = 1'b1;
        repeat (10) next_cycle();
        engine_areset = 1'b0;
        check_value("engine_ready", engine_ready, 1'b0);
        check_value("req_valid", req_valid, 1'b0);
        check_value("engine_done", engine_done, 1'b0);
        next_cycle();
        check_value("engine_ready", engine_ready, 1'b1);
        finish_test("reset_values", errors_before);
    endtask

    task automatic test_basic_stride();
        int errors_before;
        errors_before = error_count;
        clear_records();
        ready_mode = READY_HIGH;
        build_expected(32'h8000_1000, 32'h10, 32'h40, 32'h8);
        launch(32'h8000_1000, 32'h10, 32'h40, 32'h8);
        wait_for_done(1);
        wait_for_drain();
        compare_requests();
        check_value("engine_done pulses", done_count, 1);
        finish_test("basic_stride", errors_before);
    endtask

    task automatic test_empty_range();
        int errors_before;
        errors_before = error_count;
        clear_records();
        launch(32'h0000_2000, 32'h40, 32'h20, 32'h4);
        wait_for_done(1);
        wait_for_ready();
        check_value("engine_ready", engine_ready, 1'b1);
        check_value("request count", got_offset.size(), 0);
        check_value("engine_done pulses", done_count, 1);
        finish_test("empty_range", errors_before);
    endtask

    task automatic test_back_pressure();
        int errors_before;
        errors_before = error_count;
        clear_records();
        ready_mode = READY_LOW;
        next_cycle();
        build_expected(32'h4000_0000, 32'h100, 32'h1A0, 32'h4);
        launch(32'h4000_0000, 32'h100, 32'h1A0, 32'h4);
        // Long enough for the queue to reach its pause level
        repeat (3 * PAUSE_LEVEL) next_cycle();
        check_value("req_valid", req_valid, 1'b1);
        check_value("engine_ready while stalled", engine_ready, 1'b0);
        check_value("engine_done pulses while stalled", done_count, 0);
        ready_mode = READY_TOGGLE;
        wait_for_done(1);
        wait_for_drain();
        compare_requests();
        ready_mode = READY_HIGH;
        finish_test("back_pressure", errors_before);
    endtask

    task automatic test_start_without_cfg();
        int errors_before;
        int ready_low_cycles;
        errors_before = error_count;
        ready_low_cycles = 0;
        clear_records();
        wait_for_ready();
        cfg_array_pointer = 32'h1234_0000;
        cfg_start_read    = 32'h0;
        cfg_end_read      = 32'h80;
        cfg_stride        = 32'h4;
        start             = 1'b1;
        for (int i = 0; i < 24; i++) begin
            if (i == 3) begin
                start = 1'b0;
            end
            if (!engine_ready) begin
                ready_low_cycles++;
            end
            next_cycle();
        end
        check_value("engine_ready low cycles", ready_low_cycles, 0);
        check_value("request count", got_offset.size(), 0);
        check_value("engine_done pulses", done_count, 0);
        finish_test("start_without_cfg", errors_before);
    endtask

    task automatic test_random_configs();
        int          errors_before;
        logic [31:0] pointer;
        logic [31:0] stride;
        logic [31:0] start_off;
        logic [31:0] end_off;
        logic [31:0] n_req;
        logic [31:0] extra;
        errors_before = error_count;
        clear_records();
        ready_mode = READY_RANDOM;
        for (int i = 0; i < 8; i++) begin
            pointer   = $random(seed);
            stride    = ($unsigned($random(seed)) % 16) + 1;
            n_req     = $unsigned($random(seed)) % 31;
            start_off = $unsigned($random(seed)) % 32'h1000;
            // End lands anywhere in the last stride gap
            extra     = (n_req > 0) ? $unsigned($random(seed)) % stride : 0;
            end_off   = start_off + n_req * stride - extra;
            build_expected(pointer, start_off, end_off, stride);
            launch(pointer, start_off, end_off, stride);
            wait_for_done(i + 1);
        end
        wait_for_drain();
        compare_requests();
        check_value("engine_done pulses", done_count, 8);
        ready_mode = READY_HIGH;
        finish_test("random_configs", errors_before);
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------

    initial begin
        seed              = 32'ha310;
        ready_mode        = READY_HIGH;
        error_count       = 0;
        tests_run         = 0;
        tests_failed      = 0;
        done_count        = 0;
        engine_areset     = 1'b1;
        cfg_valid         = 1'b0;
        cfg_array_pointer = '0;
        cfg_start_read    = '0;
        cfg_end_read      = '0;
        cfg_stride        = '0;
        start             = 1'b0;
        req_ready         = 1'b1;

        test_reset_values();
        test_basic_stride();
        test_empty_range();
        test_back_pressure();
        test_start_without_cfg();
        test_random_configs();

        error_count += int'(serial_read_engine_inst.serial_read_engine_chk_inst.assert_failures);
        $display("Tests run: %0d, tests failed: %0d, errors: %0d",
                 tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule : serial_read_engine_tb

/* tests/tb_clock_gen.sv */
module tb_clock_gen (
    output logic ap_clk
);

    timeunit 1ns;
    timeprecision 1ps;

    // 10 ns period
    localparam time HALF_PERIOD = 5ns;

    initial begin
        ap_clk = 1'b0;
        forever #HALF_PERIOD ap_clk = ~ap_clk;
    end

endmodule : tb_clock_gen
